// File: drat_report.f
hw/drat_pkg.sv
hw/report_cfg_pkg.sv
hw/time_report_gen.sv
hw/event_report_gen.sv
hw/drat_stream_mux.sv
hw/drat_report_top.sv
sim/drat_report_sva.sv
sim/drat_report_checker.sv
sim/tb_drat_report.sv

// File: Makefile
# Verilator simulation of the DRaT report source

SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_drat_report
FILELIST := drat_report.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, then search the log for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Result: PASS" || (echo "Result: FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/tb_drat_report.sv
/*
 * Testbench for the DRaT report source.
 * Drives the system time, sparse random events and random back-pressure from
 * a Galois LFSR through three test phases. drat_report_checker compares the
 * packets and prints the per-test lines. Run with make test.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_drat_report;
   import report_cfg_pkg::*;

   localparam int C_HALF_PERIOD  = 4;
   localparam int C_RESET_CYCLES = 8;
   localparam int C_MAX_STALL    = 16;
   // Phase lengths in cycles
   localparam int C_PH0_CYCLES   = 2500;
   localparam int C_PH1_CYCLES   = 3000;
   localparam int C_OFF_CYCLES   = 300;
   localparam int C_PH2_CYCLES   = 2500;
   localparam int C_TIMEOUT      = C_PH0_CYCLES + C_PH1_CYCLES + C_OFF_CYCLES
                                   + C_PH2_CYCLES + 2000;

   logic                          clk = 1'b0;
   logic                          rst;
   logic                          csr_enable;
   logic [C_PERIOD_WIDTH-1:0]     csr_period;
   logic [31:0]                   csr_flow_id;
   logic [63:0]                   current_time;
   logic                          evt_valid;
   logic [C_EVENT_CODE_WIDTH-1:0] evt_code;
   logic                          out_valid;
   logic                          out_ready;
   logic [63:0]                   out_data;
   logic                          out_last;
   logic [1:0]                    phase;
   logic                          phase_done;
   logic                          idle;
   logic [31:0]                   err_total;
   logic [31:0]                   tests_run;
   logic [31:0]                   tests_failed;
   logic [31:0]                   lfsr;
   logic [31:0]                   rnd;
   int                            stall_cnt = 0;
   int                            cycle_cnt = 0;

   always #(C_HALF_PERIOD) clk = ~clk;

   drat_report_top drat_report_top_i (.*);

   drat_report_checker drat_report_checker_i (.*);

   // Run limit
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > C_TIMEOUT) begin
         $display("Timeout: run did not finish within %0d cycles", C_TIMEOUT);
         $display("tests failed");
         $finish;
      end
   end

   // Galois LFSR, right shifting, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // Inputs change 1 ns after the edge, events arrive with chance 2^-evt_bits
   task automatic drive_cycle(input int evt_bits, input logic stall);
      logic [31:0] r;
      @(posedge clk);
      #1;
      phase_done   = 1'b0;
      current_time = current_time + 64'd1;
      evt_valid    = 1'b0;
      if (evt_bits > 0) begin
         rand_bits(evt_bits, r);
         evt_valid = (r == 32'd0);
         if (evt_valid) begin
            rand_bits(C_EVENT_CODE_WIDTH, r);
            evt_code = r[C_EVENT_CODE_WIDTH-1:0];
         end
      end
      // Ready low at most C_MAX_STALL cycles in a row
      if (!stall || (stall_cnt >= C_MAX_STALL)) begin
         out_ready = 1'b1;
      end else begin
         rand_bits(2, r);
         out_ready = (r != 32'd0);
      end
      stall_cnt = out_ready ? 0 : stall_cnt + 1;
   endtask

   task automatic end_phase(input int evt_bits, input logic stall);
      phase_done = 1'b1;
      drive_cycle(evt_bits, stall);
   endtask

   initial begin
      lfsr         = 32'd4;
      rst          = 1'b1;
      csr_enable   = 1'b0;
      csr_period   = '0;
      evt_valid    = 1'b0;
      evt_code     = '0;
      out_ready    = 1'b0;
      phase        = 2'd0;
      phase_done   = 1'b0;
      // Period of 256 to 1024 cycles, fixed for the run
      rand_bits(2, rnd);
      csr_period[1:0] = rnd[1:0];
      rand_bits(32, rnd);
      csr_flow_id = rnd;
      rand_bits(32, rnd);
      current_time[63:32] = rnd;
      rand_bits(32, rnd);
      current_time[31:0] = rnd;
      repeat (C_RESET_CYCLES) drive_cycle(0, 1'b0);
      rst        = 1'b0;
      csr_enable = 1'b1;

      // Format and period with the sink always ready
      repeat (C_PH0_CYCLES) drive_cycle(5, 1'b0);
      end_phase(5, 1'b0);

      // Dense events under back-pressure force drops
      phase = 2'd1;
      repeat (C_PH1_CYCLES) drive_cycle(2, 1'b1);
      end_phase(2, 1'b1);

      // Disable then enable, sequence numbers restart at zero
      phase      = 2'd2;
      csr_enable = 1'b0;
      repeat (C_OFF_CYCLES) drive_cycle(3, 1'b1);
      csr_enable = 1'b1;
      repeat (C_PH2_CYCLES) drive_cycle(3, 1'b1);
      csr_enable = 1'b0;
      drive_cycle(0, 1'b0);
      while (!idle) drive_cycle(0, 1'b0);
      end_phase(0, 1'b0);

      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_total);
      if ((tests_failed == 0) && (err_total == 0)) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/drat_report_checker.sv
/*
 * Scoreboard for the DRaT report source.
 * Models the time trigger and the pending event from the top level inputs,
 * reassembles each two-beat packet at the output and compares it with the
 * model. Prints one result line per test when phase_done is seen.
 */
`timescale 1ns/1ps
`default_nettype none

module drat_report_checker (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          csr_enable,
   input  logic [report_cfg_pkg::C_PERIOD_WIDTH-1:0]     csr_period,
   input  logic [31:0]                                   csr_flow_id,
   input  logic [63:0]                                   current_time,
   input  logic                                          evt_valid,
   input  logic [report_cfg_pkg::C_EVENT_CODE_WIDTH-1:0] evt_code,
   input  logic                                          out_valid,
   input  logic                                          out_ready,
   input  logic [drat_pkg::C_BEAT_WIDTH-1:0]             out_data,
   input  logic                                          out_last,
   // Current test and its end strobe
   input  logic [1:0]                                    phase,
   input  logic                                          phase_done,
   output logic                                          idle,
   output logic [31:0]                                   err_total,
   output logic [31:0]                                   tests_run,
   output logic [31:0]                                   tests_failed
);
   import drat_pkg::*;
   import report_cfg_pkg::*;

   // Time source model
   int                            tick_cnt;
   logic                          trig_q;
   logic                          time_busy;
   logic [C_SEQ_WIDTH-1:0]        time_seq;
   int                            trig_points = 0;
   int                            time_done = 0;
   // Event source model with its single pending entry
   logic                          evt_pend;
   logic [C_EVENT_CODE_WIDTH-1:0] code_q;
   logic [31:0]                   stamp_q;
   logic [C_DROP_WIDTH-1:0]       drop_cnt;
   logic [C_DROP_WIDTH-1:0]       drop_exp;
   logic [C_SEQ_WIDTH-1:0]        evt_seq;
   logic                          evt_in;
   // Packet reassembly
   logic                          in_pkt;
   logic [7:0]                    pkt_type;
   logic                          time_end;
   logic                          evt_end;
   logic                          evt_hdr;
   int                            ph_pkts = 0;
   int                            errs = 0;
   int                            err_mark = 0;
   int                            runs = 0;
   int                            fails = 0;

   assign idle         = !time_busy && !evt_pend && !in_pkt;
   assign err_total    = errs;
   assign tests_run    = runs;
   assign tests_failed = fails;

   function automatic string test_name(input logic [1:0] ph);
      case (ph)
         2'd0:    return "format_ready";
         2'd1:    return "back_pressure";
         default: return "reenable_seq";
      endcase
   endfunction

   task automatic check_value(input string what, input logic [63:0] exp,
                              input logic [63:0] act);
      if (exp !== act) begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name(phase), what, exp, act);
         errs++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("Error in test %s: %s", test_name(phase), what);
      errs++;
   endtask

   // ------------------------------
   // Output beats against the model
   // ------------------------------

   always @(posedge clk) begin
      time_end = 1'b0;
      evt_end  = 1'b0;
      evt_hdr  = 1'b0;
      if (rst) begin
         tick_cnt  = 0;
         trig_q    = 1'b0;
         time_busy = 1'b0;
         time_seq  = '0;
         evt_pend  = 1'b0;
         drop_cnt  = '0;
         evt_seq   = '0;
         in_pkt    = 1'b0;
      end else begin
         if (out_valid && out_ready) begin
            if (!in_pkt) begin
               // Header: type, seq, length, flow id
               pkt_type = out_data[63:56];
               if (out_last) report_failure("last flag set on a header beat");
               check_value("length", 64'(C_REPORT_LENGTH), 64'(out_data[47:32]));
               check_value("flow id", 64'(csr_flow_id), 64'(out_data[31:0]));
               if (pkt_type == TIME_REPORT) begin
                  if (!time_busy) report_failure("TIME_REPORT header without a trigger");
                  check_value("time seq", 64'(time_seq), 64'(out_data[55:48]));
               end else if (pkt_type == EVENT_REPORT) begin
                  if (!evt_pend) report_failure("EVENT_REPORT header without an event");
                  check_value("event seq", 64'(evt_seq), 64'(out_data[55:48]));
                  drop_exp = drop_cnt;
                  evt_hdr  = 1'b1;
               end else begin
                  report_failure("header beat with an unknown packet type");
               end
               in_pkt = 1'b1;
            end else begin
               // Second beat, a header here means an interleaved or short packet
               if (!out_last) report_failure("second beat of a packet without last");
               if (pkt_type == TIME_REPORT) begin
                  check_value("time beat", current_time, out_data);
                  time_end = 1'b1;
                  time_done++;
               end else if (pkt_type == EVENT_REPORT) begin
                  check_value("event beat", {code_q, drop_exp, stamp_q}, out_data);
                  evt_end = 1'b1;
               end
               in_pkt = 1'b0;
               ph_pkts++;
            end
         end

         // Event entry, drops go to the count of the next report
         evt_in = evt_valid && csr_enable;
         if (evt_hdr) drop_cnt = '0;
         if (evt_in && evt_pend && (drop_cnt != '1)) drop_cnt = drop_cnt + 16'd1;
         if (evt_in && !evt_pend) begin
            code_q   = evt_code;
            stamp_q  = current_time[31:0];
            evt_pend = 1'b1;
         end
         if (evt_end) begin
            evt_seq  = evt_seq + 8'd1;
            evt_pend = 1'b0;
         end else if (!evt_pend && !csr_enable) begin
            evt_seq = '0;
         end

         // Trigger from the previous cycle, taken only when idle and enabled
         if (trig_q && csr_enable) trig_points++;
         if (trig_q && csr_enable && !time_busy) time_busy = 1'b1;
         if (time_end) begin
            time_seq  = time_seq + 8'd1;
            time_busy = 1'b0;
         end else if (!time_busy && !csr_enable) begin
            time_seq = '0;
         end
         // Every (csr_period+1)th zero low byte is a trigger point
         if (current_time[C_PRESCALE_BITS-1:0] == '0) begin
            tick_cnt++;
            trig_q = ((tick_cnt % (int'(csr_period) + 1)) == 0);
         end else begin
            trig_q = 1'b0;
         end

         if (phase_done) begin
            // One packet may still be in flight at a phase boundary
            if ((trig_points - time_done > 1) || (trig_points < time_done)) begin
               $display("[ERROR] %s time report count: expected %0d, actual %0d",
                        test_name(phase), trig_points, time_done);
               errs++;
            end
            if (errs == err_mark) begin
               $display("Test %s: passed, %0d packets", test_name(phase), ph_pkts);
            end else begin
               $display("Test %s: FAILED, %0d errors", test_name(phase), errs - err_mark);
               fails++;
            end
            err_mark = errs;
            ph_pkts  = 0;
            runs++;
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/drat_report_sva.sv
/*
 * Output stream assertions for the DRaT report source, bound to the top level.
 * A stalled beat stays offered with the same last flag and the same data.
 * The one exception is the TIME_REPORT time beat, which tracks the live
 * clock until it transfers.
 */
`timescale 1ns/1ps
`default_nettype none

module drat_report_sva (
   input logic        clk,
   input logic        rst,
   input logic        out_valid,
   input logic        out_ready,
   input logic [63:0] out_data,
   input logic        out_last
);
   import drat_pkg::*;

   // Packet type of the most recent header beat
   logic [7:0] open_type;

   always_ff @(posedge clk) begin
      if (rst) begin
         open_type <= 8'd0;
      end else if (out_valid && out_ready && !out_last) begin
         open_type <= out_data[63:56];
      end
   end

   // Stalled beat keeps valid and last
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_last))
      else $error("stalled beat dropped valid or changed last");

   // Stalled header or event beat keeps its data
   a_data_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready && (!out_last || (open_type != TIME_REPORT))
      |=> $stable(out_data))
      else $error("stalled beat changed its data");

   // Nothing offered in the cycle after a reset cycle
   a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
      else $error("output valid right after reset");

endmodule

bind drat_report_top drat_report_sva drat_report_sva_i (
   .clk       (clk),
   .rst       (rst),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_data  (out_data),
   .out_last  (out_last)
);

`default_nettype wire

// File: hw/drat_report_top.sv
/*
 * DRaT report source for the timing subsystem.
 * Periodic TIME_REPORT packets on mux port 0, EVENT_REPORT packets on
 * port 1, merged onto a single valid/ready packet stream.
 */
`timescale 1ns/1ps
`default_nettype none

module drat_report_top (
   input  logic                                          clk,
   input  logic                                          rst,
   // CSR values
   input  logic                                          csr_enable,
   input  logic [report_cfg_pkg::C_PERIOD_WIDTH-1:0]     csr_period,
   input  logic [31:0]                                   csr_flow_id,
   // System time and external events
   input  logic [63:0]                                   current_time,
   input  logic                                          evt_valid,
   input  logic [report_cfg_pkg::C_EVENT_CODE_WIDTH-1:0] evt_code,
   // Packet stream out
   output logic                                          out_valid,
   input  logic                                          out_ready,
   output logic [drat_pkg::C_BEAT_WIDTH-1:0]             out_data,
   output logic                                          out_last
);
   import drat_pkg::*;

   // TIME_REPORT stream
   logic                    tr_valid;
   logic                    tr_ready;
   logic [C_BEAT_WIDTH-1:0] tr_data;
   logic                    tr_last;
   // EVENT_REPORT stream
   logic                    er_valid;
   logic                    er_ready;
   logic [C_BEAT_WIDTH-1:0] er_data;
   logic                    er_last;

   time_report_gen time_report_gen_i (
      .clk          (clk),
      .rst          (rst),
      .csr_enable   (csr_enable),
      .csr_period   (csr_period),
      .csr_flow_id  (csr_flow_id),
      .current_time (current_time),
      .tr_valid     (tr_valid),
      .tr_ready     (tr_ready),
      .tr_data      (tr_data),
      .tr_last      (tr_last)
   );

   event_report_gen event_report_gen_i (
      .clk          (clk),
      .rst          (rst),
      .csr_enable   (csr_enable),
      .csr_flow_id  (csr_flow_id),
      .current_time (current_time),
      .evt_valid    (evt_valid),
      .evt_code     (evt_code),
      .er_valid     (er_valid),
      .er_ready     (er_ready),
      .er_data      (er_data),
      .er_last      (er_last)
   );

   // Time reports on port 0, events on port 1
   drat_stream_mux drat_stream_mux_i (
      .clk       (clk),
      .rst       (rst),
      .in0_valid (tr_valid),
      .in0_last  (tr_last),
      .in0_data  (tr_data),
      .in0_ready (tr_ready),
      .in1_valid (er_valid),
      .in1_last  (er_last),
      .in1_data  (er_data),
      .in1_ready (er_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

// File: hw/drat_stream_mux.sv
/*
 * Two-input packet merge for DRaT streams.
 * Arbitrates only between packets: a port holds the output from its first
 * beat until its last beat transfers. On a tie the port not served last
 * wins. The data path is combinational, valid passes through the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module drat_stream_mux (
   input  logic                              clk,
   input  logic                              rst,
   // Port 0
   input  logic                              in0_valid,
   input  logic                              in0_last,
   input  logic [drat_pkg::C_BEAT_WIDTH-1:0] in0_data,
   output logic                              in0_ready,
   // Port 1
   input  logic                              in1_valid,
   input  logic                              in1_last,
   input  logic [drat_pkg::C_BEAT_WIDTH-1:0] in1_data,
   output logic                              in1_ready,
   // Merged output
   output logic                              out_valid,
   output logic [drat_pkg::C_BEAT_WIDTH-1:0] out_data,
   output logic                              out_last,
   input  logic                              out_ready
);

   typedef enum logic [1:0] {
      G_NONE,
      G_PORT0,
      G_PORT1
   } grant_t;

   grant_t grant_q;
   grant_t sel;
   // High when port 1 carried the most recent packet
   logic   last_served;
   logic   xfer_last;

   // ------------------------------
   // Arbitration
   // ------------------------------

   // Open packet keeps its port, else pick among requesters now
   always_comb begin
      sel = grant_q;
      if (grant_q == G_NONE) begin
         if (in0_valid && in1_valid) begin
            sel = last_served ? G_PORT0 : G_PORT1;
         end else if (in0_valid) begin
            sel = G_PORT0;
         end else if (in1_valid) begin
            sel = G_PORT1;
         end
      end
   end

   assign xfer_last = out_valid && out_ready && out_last;

   // Lock on first valid beat, release after the last one
   always_ff @(posedge clk) begin
      if (rst) begin
         grant_q     <= G_NONE;
         last_served <= 1'b1;
      end else if (xfer_last) begin
         grant_q     <= G_NONE;
         last_served <= (sel == G_PORT1);
      end else begin
         grant_q <= sel;
      end
   end

   // ------------------------------
   // Data path
   // ------------------------------

   // Losing port sees ready low
   always_comb begin
      out_valid = 1'b0;
      out_data  = '0;
      out_last  = 1'b0;
      in0_ready = 1'b0;
      in1_ready = 1'b0;
      case (sel)
         G_PORT0: begin
            out_valid = in0_valid;
            out_data  = in0_data;
            out_last  = in0_last;
            in0_ready = out_ready;
         end
         G_PORT1: begin
            out_valid = in1_valid;
            out_data  = in1_data;
            out_last  = in1_last;
            in1_ready = out_ready;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/event_report_gen.sv
/*
 * EVENT_REPORT source for external time-stamped events.
 * An accepted event is held in a one-entry register with the low half of the
 * system time, and is emitted as header plus payload beat. Events arriving
 * while one is pending are counted as drops, saturating. The drop count is
 * reported in the next packet and restarts when that packet's header goes.
 * Payload beat, MSB first: event code(16) drop count(16) time low(32).
 */
`timescale 1ns/1ps
`default_nettype none

module event_report_gen (
   input  logic                                          clk,
   input  logic                                          rst,
   // Events ignored and sequence cleared while low
   input  logic                                          csr_enable,
   input  logic [31:0]                                   csr_flow_id,
   input  logic [63:0]                                   current_time,
   // Single-cycle event strobe with its code
   input  logic                                          evt_valid,
   input  logic [report_cfg_pkg::C_EVENT_CODE_WIDTH-1:0] evt_code,
   // Report stream out
   output logic                                          er_valid,
   input  logic                                          er_ready,
   output logic [drat_pkg::C_BEAT_WIDTH-1:0]             er_data,
   output logic                                          er_last
);
   import drat_pkg::*;
   import report_cfg_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_HEADER,
      S_EVENT
   } state_t;

   state_t                        state;
   logic [C_SEQ_WIDTH-1:0]        seq_num;
   logic [C_EVENT_CODE_WIDTH-1:0] code_q;
   logic [31:0]                   time_q;
   logic [C_DROP_WIDTH-1:0]       drop_cnt;
   logic [C_DROP_WIDTH-1:0]       drop_rep;
   logic                          pending;
   logic                          evt_take;
   logic                          evt_drop;
   logic                          hdr_xfer;

   // Entry stays pending until the last beat has left
   assign pending  = (state != S_IDLE);
   assign evt_take = csr_enable && evt_valid && !pending;
   assign evt_drop = csr_enable && evt_valid && pending;
   assign hdr_xfer = (state == S_HEADER) && er_ready;

   // ------------------------------
   // Event capture
   // ------------------------------

   always_ff @(posedge clk) begin
      if (evt_take) begin
         code_q <= evt_code;
         time_q <= current_time[31:0];
      end
   end

   // Drop counter, handed over to the packet at its header
   // A drop in the handover cycle starts the next count at one
   always_ff @(posedge clk) begin
      if (rst) begin
         drop_cnt <= '0;
      end else if (hdr_xfer) begin
         drop_cnt <= {{(C_DROP_WIDTH-1){1'b0}}, evt_drop};
      end else if (evt_drop && (drop_cnt != '1)) begin
         drop_cnt <= drop_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_xfer) begin
         drop_rep <= drop_cnt;
      end
   end

   // ------------------------------
   // Packet FSM
   // ------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE:   if (evt_take) state <= S_HEADER;
            S_HEADER: if (er_ready) state <= S_EVENT;
            S_EVENT:  if (er_ready) state <= S_IDLE;
            default:  state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         seq_num <= '0;
      end else if (!pending && !csr_enable) begin
         seq_num <= '0;
      end else if ((state == S_EVENT) && er_ready) begin
         seq_num <= seq_num + 1'b1;
      end
   end

   always_comb begin
      er_valid = pending;
      er_last  = (state == S_EVENT);
      case (state)
         S_HEADER: er_data = {EVENT_REPORT, seq_num, C_REPORT_LENGTH, csr_flow_id};
         S_EVENT:  er_data = {code_q, drop_rep, time_q};
         default:  er_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/time_report_gen.sv
/*
 * Periodic TIME_REPORT source.
 * A prescaled period counter raises a one-cycle trigger every
 * (csr_period+1)*256 time ticks. Each trigger taken while enabled emits a
 * two-beat packet: header, then the live system time. Triggers seen while a
 * packet is in flight are lost. The sequence number restarts when disabled.
 */
`timescale 1ns/1ps
`default_nettype none

module time_report_gen (
   input  logic                                      clk,
   input  logic                                      rst,
   // Low keeps the FSM idle and clears the sequence number
   input  logic                                      csr_enable,
   // Period in 256-tick units, minus one
   input  logic [report_cfg_pkg::C_PERIOD_WIDTH-1:0] csr_period,
   input  logic [31:0]                               csr_flow_id,
   // System time, advances by one per tick
   input  logic [63:0]                               current_time,
   // Report stream out
   output logic                                      tr_valid,
   input  logic                                      tr_ready,
   output logic [drat_pkg::C_BEAT_WIDTH-1:0]         tr_data,
   output logic                                      tr_last
);
   import drat_pkg::*;
   import report_cfg_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_HEADER,
      S_TIME
   } state_t;

   state_t                    state;
   logic [C_PERIOD_WIDTH-1:0] period_cnt;
   logic [C_SEQ_WIDTH-1:0]    seq_num;
   logic                      tick;
   logic                      trigger;

   // ------------------------------
   // Period counter
   // ------------------------------

   // Prescale point, once every 256 time ticks
   assign tick = (current_time[C_PRESCALE_BITS-1:0] == '0);

   // Trigger is registered, so it lands the cycle after the tick
   // Compare with >= so a lowered period cannot leave the counter stranded
   always_ff @(posedge clk) begin
      if (rst) begin
         period_cnt <= '0;
         trigger    <= 1'b0;
      end else begin
         trigger <= tick && (period_cnt >= csr_period);
         if (tick) begin
            if (period_cnt >= csr_period) begin
               period_cnt <= '0;
            end else begin
               period_cnt <= period_cnt + 1'b1;
            end
         end
      end
   end

   // ------------------------------
   // Packet FSM
   // ------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
      end else begin
         case (state)
            // Trigger while busy is simply not seen here
            S_IDLE:   if (trigger && csr_enable) state <= S_HEADER;
            S_HEADER: if (tr_ready) state <= S_TIME;
            S_TIME:   if (tr_ready) state <= S_IDLE;
            default:  state <= S_IDLE;
         endcase
      end
   end

   // Count completed packets, restart once idle and disabled
   always_ff @(posedge clk) begin
      if (rst) begin
         seq_num <= '0;
      end else if ((state == S_IDLE) && !csr_enable) begin
         seq_num <= '0;
      end else if ((state == S_TIME) && tr_ready) begin
         seq_num <= seq_num + 1'b1;
      end
   end

   // Beat mux
   // Time beat follows current_time, so it carries the value of its transfer cycle
   always_comb begin
      tr_valid = (state != S_IDLE);
      tr_last  = (state == S_TIME);
      case (state)
         S_HEADER: tr_data = {TIME_REPORT, seq_num, C_REPORT_LENGTH, csr_flow_id};
         S_TIME:   tr_data = current_time;
         default:  tr_data = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/report_cfg_pkg.sv
/*
 * Configuration field widths for the report sources.
 * CSR values reach the generators as plain inputs, these set their widths.
 */
`default_nettype none

package report_cfg_pkg;

   // csr_period width, period is counted in prescaled ticks
   localparam int C_PERIOD_WIDTH = 16;
   // Prescale of 256, counter steps when the low time byte is zero
   localparam int C_PRESCALE_BITS = 8;
   // External event code carried in EVENT_REPORT
   localparam int C_EVENT_CODE_WIDTH = 16;
   // Dropped event counter, saturates at all ones
   localparam int C_DROP_WIDTH = 16;

endpackage

`default_nettype wire

// File: hw/drat_pkg.sv
/*
 * DRaT protocol definitions shared by the report sources and the stream merge.
 * Holds the packet type encoding, the beat width, the report length and the
 * sequence number width. Modules name these in their port lists with scoped
 * names and import the package inside the body where they need more.
 */
`default_nettype none

package drat_pkg;

   // Packet type field, top byte of every header beat
   typedef enum logic [7:0] {
      TIME_REPORT  = 8'd2,
      EVENT_REPORT = 8'd3
   } pkt_type_t;

   // Width of one stream beat
   localparam int C_BEAT_WIDTH = 64;

   // Two-beat report, header plus one payload beat, in bytes
   localparam logic [15:0] C_REPORT_LENGTH = 16'd16;

   // Per-source sequence number, wraps modulo 256
   localparam int C_SEQ_WIDTH = 8;

   // Header beat, MSB first: type(8) seq(8) length(16) flow id(32)

endpackage

`default_nettype wire
